/* compile.f */
verilog/serbus_pkg.sv
verilog/bus_arbiter.sv
verilog/bus_master.sv
verilog/bus_slave.sv
verilog/serbus_top.sv
dv/serbus_props.sv
dv/serbus_tb.sv

/* dv/serbus_props.sv */
//************************************************************
// Bus protocol assertions for serbus_top and their bind
//************************************************************

`timescale 1ns/1ps

module serbus_props
(
    input logic       clk,
    input logic       arst_n,
    input logic [1:0] grant,
    input logic       bus_data,
    input logic       bus_util,
    input logic       s0_access,
    input logic       s1_access
);

    // Failed assertions, read back by the testbench at the end of the run
    int unsigned fail_count = 0;

    grant_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(grant))
    else
    begin
        fail_count++;
        $error("grant is neither one-hot nor zero");
    end

    // Nobody may pull the data line while the bus is free
    data_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
        (grant == 2'b00) |-> bus_data)
    else
    begin
        fail_count++;
        $error("bus_data is low while no grant is active");
    end

    access_in_transfer: assert property (@(posedge clk) disable iff (!arst_n)
        ($rose(s0_access) || $rose(s1_access)) |-> bus_util)
    else
    begin
        fail_count++;
        $error("slave access rose outside a transfer");
    end

endmodule

bind serbus_top serbus_props i_props
(
    .clk       (clk),
    .arst_n    (arst_n),
    .grant     (grant),
    .bus_data  (bus_data),
    .bus_util  (bus_util),
    .s0_access (s0_access),
    .s1_access (s1_access)
);

/* dv/serbus_tb.sv */
//************************************************************
// Testbench for serbus_top: clock, reset, stimulus, slave
// application model, checks, watchdog and report
//************************************************************

`timescale 1ns/1ps

module serbus_tb;

    localparam int clk_period      = 8;
    localparam int transfer_cycles = 80;
    // Cycle bounds of tests 1 to 6
    localparam int test_cycles = 20 + transfer_cycles + transfer_cycles + 60 +
                                 (2 * transfer_cycles + 64) + 8 * transfer_cycles;

    logic        clk;
    logic        arst_n;
    logic [1:0]  m_hold;
    logic [1:0]  m_execute;
    logic [1:0]  m_rw;
    logic [14:0] m_address [2];
    logic [7:0]  m_din [2];
    logic [7:0]  m_dout [2];
    logic [1:0]  m_dvalid;
    logic [1:0]  m_timeout;
    logic [1:0]  m_busy;
    logic [1:0]  s_access;
    logic [1:0]  s_access_write;
    logic [11:0] s_offset [2];
    logic [7:0]  s_wdata [2];
    logic [1:0]  s_done;
    logic [7:0]  s_rdata [2];
    logic [2:0]  done_wait [2];

    logic [31:0] rng_state = 32'h8e1e;
    logic        exp_write;
    logic [11:0] exp_offset;
    logic [7:0]  exp_wdata;
    logic [7:0]  last_rdata;
    int          exp_slave;
    int          access_count = 0;
    int          errors = 0;
    int          errors_at_start;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          last_master = 1;

    serbus_top #(.timeout_len(6)) i_dut
    (
        .clk(clk), .arst_n(arst_n),
        .m0_hold(m_hold[0]), .m0_execute(m_execute[0]), .m0_rw(m_rw[0]),
        .m0_address(m_address[0]), .m0_din(m_din[0]), .m0_dout(m_dout[0]),
        .m0_dvalid(m_dvalid[0]), .m0_timeout(m_timeout[0]), .m0_busy(m_busy[0]),
        .m1_hold(m_hold[1]), .m1_execute(m_execute[1]), .m1_rw(m_rw[1]),
        .m1_address(m_address[1]), .m1_din(m_din[1]), .m1_dout(m_dout[1]),
        .m1_dvalid(m_dvalid[1]), .m1_timeout(m_timeout[1]), .m1_busy(m_busy[1]),
        .s0_access(s_access[0]), .s0_access_write(s_access_write[0]),
        .s0_offset(s_offset[0]), .s0_wdata(s_wdata[0]),
        .s0_done(s_done[0]), .s0_rdata(s_rdata[0]),
        .s1_access(s_access[1]), .s1_access_write(s_access_write[1]),
        .s1_offset(s_offset[1]), .s1_wdata(s_wdata[1]),
        .s1_done(s_done[1]), .s1_rdata(s_rdata[1])
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        #(2 * test_cycles * clk_period);
        $display("ERROR: watchdog expired after %0d cycles, tests did not complete",
                 2 * test_cycles);
        $display("sim failed");
        $finish;
    end

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        $display("MISMATCH at %0d ns: %s expected %0h got %0h", $time, name, exp_val, got_val);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic begin_test();
        errors_at_start = errors;
    endtask

    task automatic close_test(input int num, input string name);
        if (errors == errors_at_start)
        begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: FAILED", num, name);
        end
    endtask

    // Slave application model answers each access after 1 to 4 cycles
    always @(posedge clk)
    begin
        logic [31:0] val;
        for (int s = 0; s < 2; s++)
        begin
            s_done[s] <= 1'b0;
            if (done_wait[s] != 3'd0)
            begin
                done_wait[s] <= done_wait[s] - 3'd1;
                if (done_wait[s] == 3'd1)
                    s_done[s] <= 1'b1;
            end
            if (s_access[s])
            begin
                access_count++;
                assert (exp_slave == s)
                else report_failure($sformatf("slave %0d was accessed unexpectedly", s));
                assert (s_access_write[s] == exp_write)
                else report_mismatch($sformatf("s%0d_access_write", s), exp_write,
                                     s_access_write[s]);
                assert (s_offset[s] == exp_offset)
                else report_mismatch($sformatf("s%0d_offset", s), exp_offset, s_offset[s]);
                if (exp_write)
                    assert (s_wdata[s] == exp_wdata)
                    else report_mismatch($sformatf("s%0d_wdata", s), exp_wdata, s_wdata[s]);
                val = next_rand();
                done_wait[s] <= {1'b0, val[9:8]} + 3'd1;
                s_rdata[s]   <= val[7:0];
                last_rdata   <= val[7:0];
            end
        end
    end

    task automatic acquire_bus(input int m);
        int n;
        @(posedge clk);
        m_hold[m] <= 1'b1;
        n = 0;
        while (m_busy[m] && n < 20)
        begin
            @(posedge clk);
            n++;
        end
        if (m_busy[m])
            report_failure($sformatf("master %0d was never granted the bus", m));
        else
            last_master = m;
    endtask

    task automatic release_bus(input int m);
        int n;
        @(posedge clk);
        m_hold[m] <= 1'b0;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
        end
        while (i_dut.grant != 2'b00 && n < 10);
        if (i_dut.grant != 2'b00)
            report_failure("arbiter kept the grant after hold fell");
    endtask

    task automatic run_transfer(input int m, input logic rw, input logic [14:0] addr,
                                input logic [7:0] data);
        int   n;
        int   acc_before;
        logic exp_tmo;
        // Slave id sits in the top three address bits
        exp_slave  = (addr[14:12] == 3'd5) ? 0 : (addr[14:12] == 3'd2) ? 1 : 2;
        exp_tmo    = (exp_slave == 2);
        exp_write  = rw;
        exp_offset = addr[11:0];
        exp_wdata  = data;
        acc_before = access_count;
        @(posedge clk);
        m_rw[m]      <= rw;
        m_address[m] <= addr;
        m_din[m]     <= data;
        m_execute[m] <= 1'b1;
        @(posedge clk);
        m_execute[m] <= 1'b0;
        n = 0;
        while (!m_dvalid[m] && n < 120)
        begin
            @(posedge clk);
            n++;
        end
        if (!m_dvalid[m])
        begin
            report_failure($sformatf("master %0d never raised dvalid", m));
            return;
        end
        assert (m_timeout[m] == exp_tmo)
        else report_mismatch($sformatf("m%0d_timeout", m), exp_tmo, m_timeout[m]);
        if (!exp_tmo && !rw)
            assert (m_dout[m] == last_rdata)
            else report_mismatch($sformatf("m%0d_dout", m), last_rdata, m_dout[m]);
        assert (access_count - acc_before == (exp_tmo ? 0 : 1))
        else report_mismatch("slave access count", exp_tmo ? 0 : 1, access_count - acc_before);
    endtask

    initial
    begin
        logic [31:0] r;
        logic [1:0]  exp_busy;
        int          n;
        int          m;
        int          winner;
        int          loser;
        arst_n       = 1'b0;
        m_hold       = 2'b00;
        m_execute    = 2'b00;
        m_rw         = 2'b00;
        m_address[0] = '0;
        m_address[1] = '0;
        m_din[0]     = '0;
        m_din[1]     = '0;
        s_done       = 2'b00;
        s_rdata[0]   = '0;
        s_rdata[1]   = '0;
        done_wait[0] = '0;
        done_wait[1] = '0;
        exp_slave    = 2;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        begin_test();
        repeat (8)
        begin
            @(posedge clk);
            assert (m_busy == 2'b11) else report_mismatch("m_busy", 2'b11, m_busy);
            assert (m_dvalid == 2'b00) else report_mismatch("m_dvalid", 2'b00, m_dvalid);
            assert (s_access == 2'b00) else report_mismatch("s_access", 2'b00, s_access);
            assert (i_dut.grant == 2'b00) else report_mismatch("grant", 2'b00, i_dut.grant);
        end
        close_test(1, "reset");

        begin_test();
        r = next_rand();
        acquire_bus(0);
        run_transfer(0, 1'b1, {3'd5, r[11:0]}, r[19:12]);
        release_bus(0);
        close_test(2, "write m0 to slave 5");

        begin_test();
        r = next_rand();
        acquire_bus(1);
        run_transfer(1, 1'b0, {3'd2, r[11:0]}, r[19:12]);
        release_bus(1);
        close_test(3, "read m1 from slave 2")
        ;

        // Round robin serves the master that was not served last
        begin_test();
        // Master 0 goes first alone so that the tie belongs to master 1
        acquire_bus(0);
        release_bus(0);
        winner = 1 - last_master;
        loser  = last_master;
        @(posedge clk);
        m_hold <= 2'b11;
        n = 0;
        while (m_busy == 2'b11 && n < 20)
        begin
            @(posedge clk);
            n++;
        end
        exp_busy = 2'b11;
        exp_busy[winner] = 1'b0;
        repeat (4) @(posedge clk);
        assert (m_busy == exp_busy) else report_mismatch("m_busy", exp_busy, m_busy);
        last_master = winner;
        m_hold[winner] <= 1'b0;
        n = 0;
        while (m_busy[loser] && n < 20)
        begin
            @(posedge clk);
            n++;
        end
        exp_busy = 2'b11;
        exp_busy[loser] = 1'b0;
        assert (m_busy == exp_busy) else report_mismatch("m_busy", exp_busy, m_busy);
        last_master = loser;
        release_bus(loser);
        close_test(4, "arbitration");

        begin_test();
        r = next_rand();
        acquire_bus(0);
        run_transfer(0, 1'b1, {3'd7, r[11:0]}, r[19:12]);
        run_transfer(0, 1'b0, {3'd5, r[23:12]}, r[31:24]);
        release_bus(0);
        close_test(5, "timeout");

        begin_test();
        for (int i = 0; i < 8; i++)
        begin
            r = next_rand();
            m = r[0] ? 1 : 0;
            acquire_bus(m);
            run_transfer(m, r[2], {r[1] ? 3'd5 : 3'd2, r[15:4]}, r[23:16]);
            release_bus(m);
        end
        close_test(6, "random traffic");

        $display("summary: %0d tests passed, %0d failed, %0d check errors, %0d property errors",
                 tests_passed, tests_failed, errors, i_dut.i_props.fail_count);
        if (errors == 0 && tests_failed == 0 && i_dut.i_props.fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the serial bus testbench with Verilator
set -e -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module serbus_tb \
    -f compile.f \
    -o serbus_sim

# Let assertion errors be counted instead of stopping at the first one
./obj_dir/serbus_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"

/* verilog/bus_arbiter.sv */
//************************************************************
// Round-robin arbiter for two bus masters
//************************************************************

`timescale 1ns/1ps

module bus_arbiter
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [1:0] request,
    output logic [1:0] grant
);

    // Index of the master that was granted most recently
    logic last_served;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            grant       <= 2'b00;
            last_served <= 1'b1;
        end
        else if (grant == 2'b00)
        begin
            // New grant only while the bus is free
            if (request == 2'b11)
            begin
                grant       <= last_served ? 2'b01 : 2'b10;
                last_served <= ~last_served;
            end
            else if (request[0])
            begin
                grant       <= 2'b01;
                last_served <= 1'b0;
            end
            else if (request[1])
            begin
                grant       <= 2'b10;
                last_served <= 1'b1;
            end
        end
        else if ((grant & request) == 2'b00)
        begin
            // Owner released its request
            grant <= 2'b00;
        end
    end

endmodule

/* verilog/bus_master.sv */
//************************************************************
// Bus master: request frame serializer, response receiver
// and response timeout
//************************************************************

`timescale 1ns/1ps

module bus_master
#(
    parameter int timeout_len = 6
)
(
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              hold,
    input  logic                              execute,
    input  logic                              rw,
    input  logic [serbus_pkg::addr_width-1:0] address,
    input  logic [serbus_pkg::data_width-1:0] din,
    output logic [serbus_pkg::data_width-1:0] dout,
    output logic                              dvalid,
    output logic                              timeout,
    output logic                              busy,
    output logic                              request,
    input  logic                              grant,
    input  logic                              bus_data,
    output logic                              data_drive_n,
    output logic                              rw_drive,
    output logic                              util_drive
);

    // FSM encoding
    localparam logic [2:0] st_idle       = 3'd0;
    localparam logic [2:0] st_wait_grant = 3'd1;
    localparam logic [2:0] st_ready      = 3'd2;
    localparam logic [2:0] st_send       = 3'd3;
    localparam logic [2:0] st_wait_resp  = 3'd4;
    localparam logic [2:0] st_receive    = 3'd5;

    // Start bit, rw, address and data, MSB leaves first
    localparam int frame_width = 2 + serbus_pkg::addr_width + serbus_pkg::data_width;

    logic [2:0]             state;
    logic [frame_width-1:0] shreg;
    logic [4:0]             bit_cnt;
    logic [timeout_len-1:0] tmo_cnt;
    logic                   rw_q;

    // Request simply follows hold by one cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            request <= 1'b0;
        else
            request <= hold;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= st_idle;
            bit_cnt <= 5'd0;
            tmo_cnt <= '0;
            rw_q    <= 1'b0;
            dvalid  <= 1'b0;
            timeout <= 1'b0;
        end
        else
        begin
            dvalid <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (hold)
                        state <= st_wait_grant;
                end
                st_wait_grant:
                begin
                    if (!request)
                        state <= st_idle;
                    else if (grant)
                        state <= st_ready;
                end
                st_ready:
                begin
                    if (!request)
                        state <= st_idle;
                    else if (!grant)
                        state <= st_wait_grant;
                    else if (execute)
                    begin
                        rw_q    <= rw;
                        timeout <= 1'b0;
                        bit_cnt <= rw ? serbus_pkg::write_frame_bits - 5'd1
                                      : serbus_pkg::read_frame_bits - 5'd1;
                        state   <= st_send;
                    end
                end
                st_send:
                begin
                    if (bit_cnt == 5'd0)
                    begin
                        tmo_cnt <= '0;
                        state   <= st_wait_resp;
                    end
                    else
                        bit_cnt <= bit_cnt - 5'd1;
                end
                st_wait_resp:
                begin
                    if (bus_data == serbus_pkg::start_bit_level)
                    begin
                        // A write is acknowledged by the start bit alone
                        if (rw_q)
                        begin
                            dvalid <= 1'b1;
                            state  <= st_ready;
                        end
                        else
                        begin
                            bit_cnt <= 5'd7;
                            state   <= st_receive;
                        end
                    end
                    else if (tmo_cnt == '1)
                    begin
                        dvalid  <= 1'b1;
                        timeout <= 1'b1;
                        state   <= st_ready;
                    end
                    else
                        tmo_cnt <= tmo_cnt + 1'b1;
                end
                st_receive:
                begin
                    if (bit_cnt == 5'd0)
                    begin
                        dvalid <= 1'b1;
                        state  <= st_ready;
                    end
                    else
                        bit_cnt <= bit_cnt - 5'd1;
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    // Frame shift register and read data collection
    always_ff @(posedge clk)
    begin
        if (state == st_ready && execute)
            shreg <= {serbus_pkg::start_bit_level, rw, address, din};
        else if (state == st_send)
            shreg <= {shreg[frame_width-2:0], 1'b1};

        if (state == st_receive)
            dout <= {dout[serbus_pkg::data_width-2:0], bus_data};
    end

    assign busy         = (state != st_ready);
    assign util_drive   = (state == st_send) || (state == st_wait_resp) ||
                          (state == st_receive);
    assign rw_drive     = util_drive & rw_q;
    assign data_drive_n = (state == st_send) ? shreg[frame_width-1] : 1'b1;

endmodule

/* verilog/bus_slave.sv */
//************************************************************
// Bus slave: request frame deserializer, id match, access
// report and response frame
//************************************************************

`timescale 1ns/1ps

module bus_slave
#(
    parameter logic [serbus_pkg::id_width-1:0] self_id = 3'd0
)
(
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                bus_data,
    input  logic                                bus_rw,
    input  logic                                bus_util,
    output logic                                data_drive_n,
    output logic                                access,
    output logic                                access_write,
    output logic [serbus_pkg::offset_width-1:0] offset,
    output logic [serbus_pkg::data_width-1:0]   wdata,
    input  logic                                done,
    input  logic [serbus_pkg::data_width-1:0]   rdata
);

    localparam logic [2:0] st_idle      = 3'd0;
    localparam logic [2:0] st_rx        = 3'd1;
    localparam logic [2:0] st_wait_done = 3'd2;
    localparam logic [2:0] st_tx        = 3'd3;
    localparam logic [2:0] st_skip      = 3'd4;

    // Address and data bits after the rw bit
    localparam int rx_width = serbus_pkg::addr_width + serbus_pkg::data_width;

    logic [2:0]                        state;
    logic [4:0]                        rx_cnt;
    logic [rx_width-1:0]               rx_shreg;
    logic [rx_width-1:0]               rx_next;
    logic                              rw_q;
    logic                              rx_last;
    logic                              id_match;
    serbus_pkg::bus_addr_u             rx_addr;
    logic [serbus_pkg::data_width:0]   tx_shreg;
    logic [3:0]                        tx_cnt;

    assign rx_next = {rx_shreg[rx_width-2:0], bus_data};

    // Count 0 carries rw, so the last bit is one short of the frame length
    assign rx_last = rw_q ? (rx_cnt == serbus_pkg::write_frame_bits - 5'd2)
                          : (rx_cnt == serbus_pkg::read_frame_bits - 5'd2);

    always_comb
    begin
        rx_addr.flat = rw_q ? rx_next[rx_width-1:serbus_pkg::data_width]
                            : rx_next[serbus_pkg::addr_width-1:0];
    end

    // Serial rw bit must agree with the rw line
    assign id_match = (rx_addr.split.id == self_id) && (rw_q == bus_rw);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state        <= st_idle;
            rx_cnt       <= 5'd0;
            rw_q         <= 1'b0;
            tx_cnt       <= 4'd0;
            access       <= 1'b0;
            access_write <= 1'b0;
        end
        else
        begin
            access <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (bus_util && bus_data == serbus_pkg::start_bit_level)
                    begin
                        rx_cnt <= 5'd0;
                        state  <= st_rx;
                    end
                end
                st_rx:
                begin
                    if (!bus_util)
                        state <= st_idle;
                    else if (rx_cnt == 5'd0)
                    begin
                        rw_q   <= bus_data;
                        rx_cnt <= 5'd1;
                    end
                    else if (rx_last)
                    begin
                        if (id_match)
                        begin
                            access       <= 1'b1;
                            access_write <= rw_q;
                            state        <= st_wait_done;
                        end
                        else
                            state <= st_skip;
                    end
                    else
                        rx_cnt <= rx_cnt + 5'd1;
                end
                st_wait_done:
                begin
                    // Master gave up after its timeout
                    if (!bus_util)
                        state <= st_idle;
                    else if (done)
                    begin
                        tx_cnt <= access_write ? 4'd0 : 4'd8;
                        state  <= st_tx;
                    end
                end
                st_tx:
                begin
                    if (tx_cnt == 4'd0)
                        state <= st_skip;
                    else
                        tx_cnt <= tx_cnt - 4'd1;
                end
                st_skip:
                begin
                    if (!bus_util)
                        state <= st_idle;
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        if (state == st_rx && rx_cnt != 5'd0)
            rx_shreg <= rx_next;

        if (state == st_rx && rx_cnt != 5'd0 && rx_last && id_match)
        begin
            offset <= rx_addr.split.offset;
            if (rw_q)
                wdata <= rx_next[serbus_pkg::data_width-1:0];
        end

        if (state == st_wait_done && done)
            tx_shreg <= {serbus_pkg::start_bit_level, rdata};
        else if (state == st_tx)
            tx_shreg <= {tx_shreg[serbus_pkg::data_width-1:0], 1'b1};
    end

    assign data_drive_n = (state == st_tx) ? tx_shreg[serbus_pkg::data_width] : 1'b1;

endmodule

/* verilog/serbus_pkg.sv */
//************************************************************
// Shared widths, frame constants and the address union
// for the single-wire serial bus
//************************************************************

package serbus_pkg;

    // Field widths
    localparam int data_width   = 8;
    localparam int addr_width   = 15;
    localparam int id_width     = 3;
    localparam int offset_width = 12;

    // A frame opens with a low bit on the idle-high data line
    localparam logic start_bit_level = 1'b0;

    // Request frame lengths in bits, start bit included
    localparam logic [4:0] write_frame_bits = 5'd25;
    localparam logic [4:0] read_frame_bits  = 5'd17;

    // One address word, seen flat by the master and split by the slave
    typedef union packed
    {
        logic [addr_width-1:0] flat;
        struct packed
        {
            logic [id_width-1:0]     id;
            logic [offset_width-1:0] offset;
        } split;
    } bus_addr_u;

endpackage

/* verilog/serbus_top.sv */
//************************************************************
// Two masters, two slaves, the arbiter and the wired bus
//************************************************************

`timescale 1ns/1ps

module serbus_top
#(
    parameter int timeout_len = 6
)
(
    input  logic                                clk,
    input  logic                                arst_n,
    // Master 0
    input  logic                                m0_hold,
    input  logic                                m0_execute,
    input  logic                                m0_rw,
    input  logic [serbus_pkg::addr_width-1:0]   m0_address,
    input  logic [serbus_pkg::data_width-1:0]   m0_din,
    output logic [serbus_pkg::data_width-1:0]   m0_dout,
    output logic                                m0_dvalid,
    output logic                                m0_timeout,
    output logic                                m0_busy,
    // Master 1
    input  logic                                m1_hold,
    input  logic                                m1_execute,
    input  logic                                m1_rw,
    input  logic [serbus_pkg::addr_width-1:0]   m1_address,
    input  logic [serbus_pkg::data_width-1:0]   m1_din,
    output logic [serbus_pkg::data_width-1:0]   m1_dout,
    output logic                                m1_dvalid,
    output logic                                m1_timeout,
    output logic                                m1_busy,
    // Slave 0
    output logic                                s0_access,
    output logic                                s0_access_write,
    output logic [serbus_pkg::offset_width-1:0] s0_offset,
    output logic [serbus_pkg::data_width-1:0]   s0_wdata,
    input  logic                                s0_done,
    input  logic [serbus_pkg::data_width-1:0]   s0_rdata,
    // Slave 1
    output logic                                s1_access,
    output logic                                s1_access_write,
    output logic [serbus_pkg::offset_width-1:0] s1_offset,
    output logic [serbus_pkg::data_width-1:0]   s1_wdata,
    input  logic                                s1_done,
    input  logic [serbus_pkg::data_width-1:0]   s1_rdata
);

    logic [1:0] request;
    logic [1:0] grant;
    logic [1:0] m_data_drive_n;
    logic [1:0] m_rw_drive;
    logic [1:0] m_util_drive;
    logic [1:0] s_data_drive_n;
    logic       bus_data;
    logic       bus_rw;
    logic       bus_util;

    // Wired-AND data line idles high, the other lines idle low
    assign bus_data = &{m_data_drive_n, s_data_drive_n};
    assign bus_rw   = |m_rw_drive;
    assign bus_util = |m_util_drive;

    bus_arbiter i_arbiter
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .request (request),
        .grant   (grant)
    );

    bus_master #(.timeout_len(timeout_len)) i_master_0
    (
        .clk(clk), .arst_n(arst_n),
        .hold(m0_hold), .execute(m0_execute), .rw(m0_rw),
        .address(m0_address), .din(m0_din), .dout(m0_dout),
        .dvalid(m0_dvalid), .timeout(m0_timeout), .busy(m0_busy),
        .request(request[0]), .grant(grant[0]), .bus_data(bus_data),
        .data_drive_n(m_data_drive_n[0]), .rw_drive(m_rw_drive[0]),
        .util_drive(m_util_drive[0])
    );

    bus_master #(.timeout_len(timeout_len)) i_master_1
    (
        .clk(clk), .arst_n(arst_n),
        .hold(m1_hold), .execute(m1_execute), .rw(m1_rw),
        .address(m1_address), .din(m1_din), .dout(m1_dout),
        .dvalid(m1_dvalid), .timeout(m1_timeout), .busy(m1_busy),
        .request(request[1]), .grant(grant[1]), .bus_data(bus_data),
        .data_drive_n(m_data_drive_n[1]), .rw_drive(m_rw_drive[1]),
        .util_drive(m_util_drive[1])
    );

    bus_slave #(.self_id(3'd5)) i_slave_0
    (
        .clk(clk), .arst_n(arst_n),
        .bus_data(bus_data), .bus_rw(bus_rw), .bus_util(bus_util),
        .data_drive_n(s_data_drive_n[0]),
        .access(s0_access), .access_write(s0_access_write),
        .offset(s0_offset), .wdata(s0_wdata),
        .done(s0_done), .rdata(s0_rdata)
    );

    bus_slave #(.self_id(3'd2)) i_slave_1
    (
        .clk(clk), .arst_n(arst_n),
        .bus_data(bus_data), .bus_rw(bus_rw), .bus_util(bus_util),
        .data_drive_n(s_data_drive_n[1]),
        .access(s1_access), .access_write(s1_access_write),
        .offset(s1_offset), .wdata(s1_wdata),
        .done(s1_done), .rdata(s1_rdata)
    );

endmodule
